// File: logic/imuldiv_pkg.sv
// shared types and helpers for the iterative multiply/divide unit
// compile this before the interfaces and RTL modules
`default_nettype none

package imuldiv_pkg;

  // --------------------
  // opcodes
  // --------------------

  // signed ops first in each pair
  typedef enum logic [1:0] {
    OP_MUL  = 2'd0,
    OP_MULU = 2'd1,
    OP_DIV  = 2'd2,
    OP_DIVU = 2'd3
  } imuldiv_op_e;

  // --------------------
  // execute FSM states
  // --------------------

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } imuldiv_state_e;

  // true for both divide opcodes
  function automatic logic is_div(input imuldiv_op_e op);
    return (op == OP_DIV) || (op == OP_DIVU);
  endfunction

  // bits needed for an iteration counter that runs 0 .. width-1
  function automatic int cnt_bits(input int width);
    return (width > 1) ? $clog2(width) : 1;
  endfunction

endpackage

`default_nettype wire

// File: logic/imuldiv_op_if.sv
// decode to execute link, carries operand magnitudes and sign flags
// decode owns the payload and val, execute answers with rdy
`timescale 1ns/1ns
`default_nettype none

interface imuldiv_op_if #(
  parameter int WIDTH = 32
);
  import imuldiv_pkg::*;

  logic             val;
  logic             rdy;
  imuldiv_op_e      op;
  // unsigned magnitudes of the two operands
  logic [WIDTH-1:0] mag_a;
  logic [WIDTH-1:0] mag_b;
  // product or quotient must be negated
  logic             neg_prod;
  // remainder must be negated
  logic             neg_rem;

  modport decode_mp (output val, op, mag_a, mag_b, neg_prod, neg_rem, input rdy);

  modport execute_mp (input val, op, mag_a, mag_b, neg_prod, neg_rem, output rdy);

endinterface

`default_nettype wire

// File: logic/imuldiv_res_if.sv
// execute to result link, carries the unsigned raw result
// plus what result needs to restore the signs
`timescale 1ns/1ns
`default_nettype none

interface imuldiv_res_if #(
  parameter int WIDTH = 32
);

  logic               val;
  logic               rdy;
  logic               is_div;
  // product, or {remainder, quotient} for divides
  logic [2*WIDTH-1:0] raw;
  logic               neg_prod;
  logic               neg_rem;
  // divisor was zero at load
  logic               div_zero;

  modport execute_mp (
    output val, is_div, raw, neg_prod, neg_rem, div_zero,
    input  rdy
  );

  modport result_mp (
    input  val, is_div, raw, neg_prod, neg_rem, div_zero,
    output rdy
  );

endinterface

`default_nettype wire

// File: logic/imuldiv_mul_dpath.sv
// shift-add multiplier on unsigned magnitudes
// load once, then one step per multiplier bit
`timescale 1ns/1ns
`default_nettype none

module imuldiv_mul_dpath #(
  parameter int WIDTH = 32
) (
  input  logic               clk,
  input  logic               load,
  input  logic               step,
  input  logic [WIDTH-1:0]   mag_a,
  input  logic [WIDTH-1:0]   mag_b,
  output logic [2*WIDTH-1:0] product
);

  // multiplicand widened so it can shift left WIDTH times
  logic [2*WIDTH-1:0] mcand;
  logic [WIDTH-1:0]   mplier;
  logic [2*WIDTH-1:0] acc;

  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {{WIDTH{1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
    end else if (step) begin
      // partial product only when the current multiplier bit is set
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // valid once all WIDTH steps are done
  assign product = acc;

endmodule

`default_nettype wire

// File: logic/imuldiv_div_dpath.sv
// restoring divider on unsigned magnitudes, one quotient bit per step
// a zero divisor falls out as all-ones quotient and dividend remainder
`timescale 1ns/1ns
`default_nettype none

module imuldiv_div_dpath #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             load,
  input  logic             step,
  input  logic [WIDTH-1:0] mag_a,
  input  logic [WIDTH-1:0] mag_b,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder
);

  logic [WIDTH-1:0] rem_q;
  // dividend bits leave at the top, quotient bits enter at the bottom
  logic [WIDTH-1:0] quo_q;
  logic [WIDTH-1:0] divisor_q;
  logic [WIDTH:0]   part;
  logic             fits;
  logic [WIDTH-1:0] diff;

  // --------------------
  // one step
  // --------------------

  // partial remainder with the next dividend bit shifted in
  assign part = {rem_q, quo_q[WIDTH-1]};

  // subtract only if it does not underflow
  assign fits = part >= {1'b0, divisor_q};

  // difference is below the divisor when it fits, so WIDTH bits hold it
  assign diff = WIDTH'(part - {1'b0, divisor_q});

  always_ff @(posedge clk) begin
    if (load) begin
      rem_q     <= '0;
      quo_q     <= mag_a;
      divisor_q <= mag_b;
    end else if (step) begin
      rem_q <= fits ? diff : part[WIDTH-1:0];
      quo_q <= {quo_q[WIDTH-2:0], fits};
    end
  end

  assign quotient  = quo_q;
  assign remainder = rem_q;

endmodule

`default_nettype wire

// File: logic/imuldiv_decode.sv
// request stage, one entry deep
// turns signed operands into magnitudes and records the result signs
`timescale 1ns/1ns
`default_nettype none

module imuldiv_decode #(
  parameter int WIDTH = 32
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_val,
  output logic                    req_rdy,
  input  imuldiv_pkg::imuldiv_op_e req_op,
  input  logic [WIDTH-1:0]        req_a,
  input  logic [WIDTH-1:0]        req_b,
  imuldiv_op_if.decode_mp         op
);
  import imuldiv_pkg::*;

  logic is_signed;
  logic sign_a;
  logic sign_b;
  logic take;

  // only the signed opcodes look at the top bits
  assign is_signed = (req_op == OP_MUL) || (req_op == OP_DIV);
  assign sign_a    = is_signed && req_a[WIDTH-1];
  assign sign_b    = is_signed && req_b[WIDTH-1];

  // free slot, or the current entry moves on this cycle
  assign req_rdy = !op.val || op.rdy;
  assign take    = req_val && req_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      op.val <= 1'b0;
    end else if (take) begin
      op.val <= 1'b1;
    end else if (op.rdy) begin
      op.val <= 1'b0;
    end
  end

  // payload, written on accept only
  always_ff @(posedge clk) begin
    if (take) begin
      op.op    <= req_op;
      // most negative value maps to 2**(WIDTH-1), still fits unsigned
      op.mag_a <= sign_a ? -req_a : req_a;
      op.mag_b <= sign_b ? -req_b : req_b;
      op.neg_prod <= sign_a ^ sign_b;
      // remainder follows the dividend
      op.neg_rem  <= sign_a && is_div(req_op);
    end
  end

  // an offered entry stays until execute takes it
  a_op_hold: assert property (@(posedge clk) disable iff (reset)
    op.val && !op.rdy |=> op.val);

endmodule

`default_nettype wire

// File: logic/imuldiv_execute.sv
// iteration stage, runs WIDTH steps of the multiply or divide datapath
// one item at a time, handed to result from ST_DONE
`timescale 1ns/1ns
`default_nettype none

module imuldiv_execute #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             reset,
  imuldiv_op_if.execute_mp  op,
  imuldiv_res_if.execute_mp res
);
  import imuldiv_pkg::*;

  // one spare bit so the count can show an overrun past WIDTH-1
  localparam int               CNT_W    = cnt_bits(WIDTH) + 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WIDTH - 1);

  imuldiv_state_e     state;
  logic [CNT_W-1:0]   cnt;
  imuldiv_op_e        op_q;
  logic               neg_prod_q;
  logic               neg_rem_q;
  logic               div_zero_q;
  logic               take;
  logic               load_mul;
  logic               load_div;
  logic               step_mul;
  logic               step_div;
  logic [2*WIDTH-1:0] product;
  logic [WIDTH-1:0]   quotient;
  logic [WIDTH-1:0]   remainder;

  // --------------------
  // control
  // --------------------

  assign op.rdy = (state == ST_IDLE);
  assign take   = op.val && op.rdy;

  // only the datapath that matches the opcode moves
  assign load_mul = take && !is_div(op.op);
  assign load_div = take && is_div(op.op);
  assign step_mul = (state == ST_CALC) && !is_div(op_q);
  assign step_div = (state == ST_CALC) && is_div(op_q);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (take) begin
            state <= ST_CALC;
            cnt   <= '0;
          end
        end
        ST_CALC: begin
          // last step happens on this edge
          if (cnt == CNT_LAST) begin
            state <= ST_DONE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        ST_DONE: begin
          if (res.rdy) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // opcode and sign info ride along with the item
  always_ff @(posedge clk) begin
    if (take) begin
      op_q       <= op.op;
      neg_prod_q <= op.neg_prod;
      neg_rem_q  <= op.neg_rem;
      div_zero_q <= (op.mag_b == '0);
    end
  end

  // --------------------
  // datapaths
  // --------------------

  imuldiv_mul_dpath #(.WIDTH(WIDTH)) mul_dpath_inst (
    .clk     (clk),
    .load    (load_mul),
    .step    (step_mul),
    .mag_a   (op.mag_a),
    .mag_b   (op.mag_b),
    .product (product)
  );

  imuldiv_div_dpath #(.WIDTH(WIDTH)) div_dpath_inst (
    .clk       (clk),
    .load      (load_div),
    .step      (step_div),
    .mag_a     (op.mag_a),
    .mag_b     (op.mag_b),
    .quotient  (quotient),
    .remainder (remainder)
  );

  assign res.val      = (state == ST_DONE);
  assign res.is_div   = is_div(op_q);
  assign res.raw      = is_div(op_q) ? {remainder, quotient} : product;
  assign res.neg_prod = neg_prod_q;
  assign res.neg_rem  = neg_rem_q;
  assign res.div_zero = div_zero_q;

  a_cnt_range: assert property (@(posedge clk) disable iff (reset)
    state == ST_CALC |-> cnt <= CNT_LAST);

  // an accepted item is offered to result after WIDTH steps
  a_accept_idle: assert property (@(posedge clk) disable iff (reset)
    op.val && op.rdy |-> ##(WIDTH + 1) res.val);

endmodule

`default_nettype wire

// File: logic/imuldiv_result.sv
// response stage, restores signs and holds the response
// until the consumer raises resp_rdy
`timescale 1ns/1ns
`default_nettype none

module imuldiv_result #(
  parameter int WIDTH = 32
) (
  input  logic               clk,
  input  logic               reset,
  imuldiv_res_if.result_mp   res,
  output logic               resp_val,
  input  logic               resp_rdy,
  output logic [2*WIDTH-1:0] resp_result
);

  logic [WIDTH-1:0]   quo;
  logic [WIDTH-1:0]   rem;
  logic [WIDTH-1:0]   quo_fix;
  logic [WIDTH-1:0]   rem_fix;
  logic [2*WIDTH-1:0] prod_fix;
  logic [2*WIDTH-1:0] outcome;
  logic               take;

  // --------------------
  // sign restore
  // --------------------

  assign rem = res.raw[2*WIDTH-1:WIDTH];
  assign quo = res.raw[WIDTH-1:0];

  // divide by zero keeps the all-ones quotient as is
  assign quo_fix  = (res.neg_prod && !res.div_zero) ? -quo : quo;
  assign rem_fix  = res.neg_rem ? -rem : rem;
  assign prod_fix = res.neg_prod ? -res.raw : res.raw;
  assign outcome  = res.is_div ? {rem_fix, quo_fix} : prod_fix;

  // holding register empty, or being read this cycle
  assign res.rdy = !resp_val || resp_rdy;
  assign take    = res.val && res.rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (take) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      resp_result <= outcome;
    end
  end

  // a stalled response keeps its value
  a_resp_stable: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_result));

endmodule

`default_nettype wire

// File: logic/imuldiv_top.sv
// top level of the iterative multiply/divide unit
// decode, execute and result in a row, val/rdy on both ends
`timescale 1ns/1ns
`default_nettype none

module imuldiv_top #(
  parameter int WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     reset,
  // request side
  input  logic                     req_val,
  output logic                     req_rdy,
  input  imuldiv_pkg::imuldiv_op_e req_op,
  input  logic [WIDTH-1:0]         req_a,
  input  logic [WIDTH-1:0]         req_b,
  // response side
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output logic [2*WIDTH-1:0]       resp_result
);

  imuldiv_op_if  #(.WIDTH(WIDTH)) op_bus ();
  imuldiv_res_if #(.WIDTH(WIDTH)) res_bus ();

  // --------------------
  // stages
  // --------------------

  imuldiv_decode #(.WIDTH(WIDTH)) decode_inst (
    .clk     (clk),
    .reset   (reset),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .req_op  (req_op),
    .req_a   (req_a),
    .req_b   (req_b),
    .op      (op_bus.decode_mp)
  );

  imuldiv_execute #(.WIDTH(WIDTH)) execute_inst (
    .clk   (clk),
    .reset (reset),
    .op    (op_bus.execute_mp),
    .res   (res_bus.execute_mp)
  );

  imuldiv_result #(.WIDTH(WIDTH)) result_inst (
    .clk         (clk),
    .reset       (reset),
    .res         (res_bus.result_mp),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

endmodule

`default_nettype wire

// File: tb/imuldiv_tb.sv
// table-driven testbench for the iterative multiply/divide unit
// hand rows then xorshift rows, expected values from an arithmetic model
`timescale 1ns/1ns
`default_nettype none

module imuldiv_tb;
  import imuldiv_pkg::*;

  localparam int          WIDTH          = 32;
  localparam int          NUM_HAND       = 16;
  localparam int          NUM_ROWS       = NUM_HAND + 24;
  localparam int          TIMEOUT_CYCLES = NUM_ROWS * (WIDTH + 3) * 4 + 200;
  localparam logic [31:0] SEED           = 32'hbcde0fbb;

  logic               clk;
  logic               reset;
  logic               req_val;
  logic               req_rdy;
  imuldiv_op_e        req_op;
  logic [WIDTH-1:0]   req_a;
  logic [WIDTH-1:0]   req_b;
  logic               resp_val;
  logic               resp_rdy;
  logic [2*WIDTH-1:0] resp_result;

  // stimulus table, expected column filled when a row is queued
  string              row_name [NUM_ROWS];
  imuldiv_op_e        row_op   [NUM_ROWS];
  logic [WIDTH-1:0]   row_a    [NUM_ROWS];
  logic [WIDTH-1:0]   row_b    [NUM_ROWS];
  logic [2*WIDTH-1:0] row_exp  [NUM_ROWS];

  // in-order scoreboard
  string              exp_name_q [$];
  logic [2*WIDTH-1:0] exp_val_q  [$];

  logic [31:0] rng_state;
  logic        rand_phase;
  int          resp_count;
  int          stall_cycles;
  int          value_errors;
  int          other_errors;

  imuldiv_top #(.WIDTH(WIDTH)) imuldiv_top_inst (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  always #4 clk = ~clk;

  // --------------------
  // helpers
  // --------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // quotient truncates toward zero, remainder takes the dividend sign
  // zero divisor gives all-ones quotient and the dividend back
  function automatic logic [2*WIDTH-1:0] model_result(input imuldiv_op_e op,
      input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
    longint           sa;
    longint           sb;
    logic [WIDTH-1:0] quo;
    logic [WIDTH-1:0] rem;
    sa  = $signed(a);
    sb  = $signed(b);
    quo = '1;
    rem = a;
    case (op)
      OP_MUL:  return sa * sb;
      OP_MULU: return {{WIDTH{1'b0}}, a} * {{WIDTH{1'b0}}, b};
      OP_DIV: begin
        if (b != '0) begin
          quo = WIDTH'(sa / sb);
          rem = WIDTH'(sa % sb);
        end
      end
      default: begin
        if (b != '0) begin
          quo = a / b;
          rem = a % b;
        end
      end
    endcase
    return {rem, quo};
  endfunction

  task automatic set_row(input int idx, input string name, input imuldiv_op_e op,
      input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
    row_name[idx] = name;
    row_op[idx]   = op;
    row_a[idx]    = a;
    row_b[idx]    = b;
  endtask

  task automatic build_table();
    set_row(0,  "mul_zero",     OP_MUL,  32'h0,        32'h1234);
    set_row(1,  "mul_ones",     OP_MUL,  32'h1,        32'h1);
    set_row(2,  "mul_neg_one",  OP_MUL,  32'hffffffff, 32'hffffffff);
    set_row(3,  "mul_min_sq",   OP_MUL,  32'h80000000, 32'h80000000);
    set_row(4,  "mul_mixed",    OP_MUL,  32'hfffffff9, 32'h6);
    set_row(5,  "mulu_max",     OP_MULU, 32'hffffffff, 32'hffffffff);
    set_row(6,  "mulu_min",     OP_MULU, 32'h80000000, 32'h2);
    set_row(7,  "div_pos",      OP_DIV,  32'd100,      32'd7);
    set_row(8,  "div_neg_a",    OP_DIV,  -32'sd100,    32'd7);
    set_row(9,  "div_neg_b",    OP_DIV,  32'd100,      -32'sd7);
    set_row(10, "div_min_neg1", OP_DIV,  32'h80000000, 32'hffffffff);
    set_row(11, "div_zero",     OP_DIV,  -32'sd5,      32'h0);
    set_row(12, "divu_max",     OP_DIVU, 32'hffffffff, 32'd10);
    set_row(13, "divu_zero",    OP_DIVU, 32'h12345678, 32'h0);
    set_row(14, "divu_small",   OP_DIVU, 32'h3,        32'hffffffff);
    set_row(15, "div_one",      OP_DIV,  32'h7fffffff, 32'h1);
    for (int i = NUM_HAND; i < NUM_ROWS; i++) begin
      rng_state  = xorshift32(rng_state);
      row_op[i]  = imuldiv_op_e'(rng_state[1:0]);
      row_name[i] = $sformatf("rand_%0d", i - NUM_HAND);
      rng_state  = xorshift32(rng_state);
      row_a[i]   = rng_state;
      rng_state  = xorshift32(rng_state);
      // half the divisors small, so quotients are not all zero
      row_b[i]   = rng_state[31] ? rng_state : {24'b0, rng_state[7:0]};
    end
  endtask

  // --------------------
  // checks
  // --------------------

  task automatic check_result(input string name, input logic [2*WIDTH-1:0] expected,
      input logic [2*WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %b actual %b", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  // --------------------
  // response side
  // --------------------

  // resp_rdy held high at first, random once the xorshift rows start
  always @(posedge clk) begin
    if (reset) begin
      resp_rdy <= 1'b0;
    end else if (rand_phase) begin
      rng_state = xorshift32(rng_state);
      resp_rdy <= rng_state[7];
    end else begin
      resp_rdy <= 1'b1;
    end
  end

  // sampled mid-cycle, a transfer happens on the next rising edge
  always @(negedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      if (exp_val_q.size() == 0) begin
        $display("response arrived with no request outstanding");
        other_errors++;
      end else begin
        check_result(exp_name_q.pop_front(), exp_val_q.pop_front(), resp_result);
      end
      resp_count++;
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d of %0d responses seen",
             cycles, resp_count, NUM_ROWS);
    other_errors++;
    finish_run();
  end

  // --------------------
  // request side
  // --------------------

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    req_val      = 1'b0;
    req_op       = OP_MUL;
    req_a        = '0;
    req_b        = '0;
    resp_rdy     = 1'b0;
    rand_phase   = 1'b0;
    resp_count   = 0;
    stall_cycles = 0;
    value_errors = 0;
    other_errors = 0;
    rng_state    = SEED;
    build_table();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_flag("reset_resp_val", 1'b0, resp_val);
    check_flag("reset_req_rdy", 1'b1, req_rdy);
    @(posedge clk);
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (i == NUM_HAND) begin
        rand_phase <= 1'b1;
      end
      req_val <= 1'b1;
      req_op  <= row_op[i];
      req_a   <= row_a[i];
      req_b   <= row_b[i];
      row_exp[i] = model_result(row_op[i], row_a[i], row_b[i]);
      exp_name_q.push_back(row_name[i]);
      exp_val_q.push_back(row_exp[i]);
      // hold the request until decode has room
      @(negedge clk);
      while (!req_rdy) begin
        stall_cycles++;
        @(negedge clk);
      end
      @(posedge clk);
    end
    req_val <= 1'b0;
    while (resp_count < NUM_ROWS) begin
      @(negedge clk);
    end
    // extra time so a duplicated response would still show up
    repeat (2 * (WIDTH + 3)) @(negedge clk);
    check_count("response_count", NUM_ROWS, resp_count);
    if (stall_cycles == 0) begin
      $display("req_rdy never dropped although the pipeline should have filled");
      other_errors++;
    end
    finish_run();
  end

endmodule

`default_nettype wire

// File: tb.f
logic/imuldiv_pkg.sv
logic/imuldiv_op_if.sv
logic/imuldiv_res_if.sv
logic/imuldiv_mul_dpath.sv
logic/imuldiv_div_dpath.sv
logic/imuldiv_decode.sv
logic/imuldiv_execute.sv
logic/imuldiv_result.sv
logic/imuldiv_top.sv
tb/imuldiv_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module imuldiv_tb -Mdir obj_dir \
  && ./obj_dir/Vimuldiv_tb > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log \
  && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
